//--- ram512k_testdata.txt
# Columns: mreq_b iorq_b wr_b rfsh_b m1_b adr15 adr14 data(hex) mode(ovr,shd) ready ramrd_b
#          then expected ramcs_b ramdis ramadrhi rd_ovr adr15_ovr ramwe_b ramoe_b
# Reset values, then a read in scheme 0 stays on internal RAM
0 1 1 1 1 0 0 00 00 1 0  1 0 01100 0 0 1 0
1 1 1 1 1 0 0 00 00 1 1  1 0 01100 0 0 1 1
1 1 1 1 1 0 0 00 00 1 1  1 0 01100 0 0 1 1
# Control write bank 5 scheme 2, then the four quarters
1 0 0 1 1 0 0 EA 00 1 1  1 1 10100 0 0 0 1
0 1 1 1 1 0 0 00 00 1 0  0 1 10100 0 0 1 0
0 1 1 1 1 0 1 00 00 1 0  0 1 10101 0 0 1 0
0 1 1 1 1 1 0 00 00 1 0  0 1 10110 0 0 1 0
0 1 1 1 1 1 1 00 00 1 0  0 1 10111 0 0 1 0
# Writes with adr15 high or tag 10 are ignored
1 0 0 1 1 1 0 C1 00 1 1  1 1 10110 0 0 0 1
1 0 0 1 1 0 0 81 00 1 1  1 1 10100 0 0 0 1
0 1 1 1 1 1 1 00 00 1 0  0 1 10111 0 0 1 0
# Scheme 1 bank 2
1 0 0 1 1 0 0 D1 00 1 1  1 0 01100 0 0 0 1
0 1 1 1 1 1 0 00 00 1 0  1 0 01110 0 0 1 0
0 1 1 1 1 1 1 00 00 1 0  0 1 01011 0 0 1 0
# Scheme 6 bank 7
1 0 0 1 1 0 0 FE 00 1 1  1 0 01100 0 0 0 1
0 1 0 1 1 0 1 00 00 1 1  0 1 11110 0 0 0 1
0 1 1 1 1 1 1 00 00 1 0  1 0 01111 0 0 1 0
# Scheme 3 bank 1 decodes on the held adr15
1 0 0 1 1 0 0 CB 00 1 1  1 0 01100 0 0 0 1
1 1 1 1 1 1 1 00 00 1 1  1 1 00111 0 0 1 1
0 1 1 1 1 0 1 00 00 1 0  0 1 00111 0 0 1 0
1 1 1 1 1 0 1 00 00 1 1  1 0 01101 0 0 1 1
0 1 1 1 1 0 1 00 00 1 0  1 0 01101 0 0 1 0
# 464 mode with scheme 3, adr15 overdrive follows mreq_b
1 1 1 1 1 0 0 00 10 1 1  1 0 01100 0 0 1 1
0 1 1 1 1 0 1 00 10 1 0  1 0 01101 0 1 1 0
1 1 1 1 1 0 0 00 10 1 1  1 0 01100 0 0 1 1
1 1 1 1 1 0 0 00 10 1 1  1 0 01100 0 0 1 1
# 464 mode scheme 2 bank 6, expansion write with wait states
1 0 0 1 1 0 0 F2 10 1 1  1 1 11000 0 0 0 1
0 1 0 1 1 1 0 00 10 0 1  0 1 11010 1 0 0 1
0 1 0 1 1 1 0 00 10 0 1  0 1 11010 1 0 0 1
0 1 0 1 1 1 0 00 10 1 1  0 1 11010 1 0 0 1
0 1 0 1 1 1 0 00 10 1 1  0 1 11010 1 0 0 1
1 1 1 1 1 0 0 00 10 1 1  1 1 11000 0 0 1 1
# Refresh and M1 cycles never raise the read overdrive
0 1 1 0 1 0 0 00 10 1 0  1 1 11000 0 0 1 0
1 1 1 1 1 0 0 00 10 1 1  1 1 11000 0 0 1 1
0 1 1 1 0 0 0 00 10 1 0  0 1 11000 0 0 1 0
1 1 1 1 1 0 0 00 10 1 1  1 1 11000 0 0 1 1
# Shadow mode, bank 3 is aliased to bank 1
1 0 0 1 1 0 0 D9 01 1 1  1 0 01100 0 0 0 1
0 1 1 1 1 1 1 00 01 1 0  0 1 00111 0 0 1 0
1 1 1 1 1 0 0 00 01 1 1  1 1 01100 0 0 1 1
1 1 1 1 1 0 0 00 01 1 1  1 0 01100 0 0 1 1
0 1 0 1 1 0 1 00 01 1 1  0 1 01101 0 0 0 1
0 1 0 1 1 0 1 00 01 1 1  0 1 01101 0 0 0 1
0 1 0 1 1 0 1 00 01 1 1  1 0 01101 0 0 0 1
1 1 1 1 1 0 0 00 01 1 1  1 0 01100 0 0 1 1
# Shadow plus 464, scheme 3 bank 2
1 0 0 1 1 0 0 D3 11 1 1  1 0 01100 0 0 0 1
0 1 0 1 1 0 1 00 11 1 1  0 1 01111 0 1 0 1
0 1 0 1 1 0 1 00 11 1 1  0 1 01111 0 1 0 1
0 1 0 1 1 0 1 00 11 1 1  0 1 01111 0 0 0 1
1 1 1 1 1 0 0 00 11 1 1  1 0 01100 0 0 1 1

//--- tb.f
+incdir+.
cpc_bus_pkg.sv
ram_map_pkg.sv
bank_select_reg.sv
mem_write_fsm.sv
ram_mapper.sv
ram512k_top.sv
ram512k_props.sv
ram512k_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ram512k_tb -f tb.f -o ram512k_sim

./obj_dir/ram512k_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  exit 1
fi
exit 0

//--- ram512k_tb.sv
// Testbench for the 512K RAM card with vector reader, compare tasks and watchdog
`timescale 1ns/10ps
`default_nettype none

module ram512k_tb;

  localparam int MAX_VEC = 256;

  logic                     clk;
  logic                     reset_b;
  cpc_bus_pkg::cpu_bus_t    bus;
  cpc_bus_pkg::card_mode_t  mode;
  logic                     ready;
  logic                     ramrd_b;
  ram_map_pkg::ram_ctrl_t   ctrl;
  logic                     ramwe_b;
  logic                     ramoe_b;

  // Vectors loaded from the data file
  cpc_bus_pkg::cpu_bus_t    vec_bus [MAX_VEC];
  cpc_bus_pkg::card_mode_t  vec_mode [MAX_VEC];
  logic                     vec_ready [MAX_VEC];
  logic                     vec_ramrd [MAX_VEC];
  ram_map_pkg::ram_ctrl_t   vec_ctrl [MAX_VEC];
  logic                     vec_we [MAX_VEC];
  logic                     vec_oe [MAX_VEC];
  int                       vec_count;
  logic                     loaded;

  int ctrl_errors;
  int bit_errors;
  int other_errors;

  ram512k_top ram512k_top_i (
    .clk     (clk),
    .reset_b (reset_b),
    .bus     (bus),
    .mode    (mode),
    .ready   (ready),
    .ramrd_b (ramrd_b),
    .ctrl    (ctrl),
    .ramwe_b (ramwe_b),
    .ramoe_b (ramoe_b)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Spells out the fields of a control struct in SRAM pin order
  function automatic string format_ctrl(input ram_map_pkg::ram_ctrl_t c);
    return $sformatf("cs=%b dis=%b hi=%b rdo=%b a15o=%b",
                     c.ramcs_b, c.ramdis, c.ramadrhi, c.rd_overdrive, c.adr15_overdrive);
  endfunction

  // The control struct is compared as one value
  task automatic check_ctrl(input string name, input ram_map_pkg::ram_ctrl_t exp,
                            input ram_map_pkg::ram_ctrl_t act);
    if (act !== exp) begin
      ctrl_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %s actual %s",
               $time, name, format_ctrl(exp), format_ctrl(act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Comment lines start with a hash and every other line carries 18 fields
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic        f_m, f_i, f_w, f_f, f_m1, f_a15, f_a14;
    logic [7:0]  f_d;
    logic [1:0]  f_mode;
    logic        f_rdy, f_rrd, f_cs, f_dis, f_rdo, f_a15o, f_we, f_oe;
    logic [4:0]  f_hi;
    fd = $fopen("ram512k_testdata.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open the vector file ram512k_testdata.txt");
      return;
    end
    while (!$feof(fd) && vec_count < MAX_VEC) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() < 2 || line.getc(0) == 8'h23) begin
        continue;
      end
      n = $sscanf(line, "%b %b %b %b %b %b %b %h %b %b %b %b %b %b %b %b %b %b",
                  f_m, f_i, f_w, f_f, f_m1, f_a15, f_a14, f_d, f_mode, f_rdy, f_rrd,
                  f_cs, f_dis, f_hi, f_rdo, f_a15o, f_we, f_oe);
      if (n != 18) begin
        other_errors++;
        $display("Malformed vector line, only %0d fields read: %s", n, line);
        continue;
      end
      vec_bus[vec_count]   = {f_m, f_i, f_w, f_f, f_m1, f_a15, f_a14, f_d[7:3], f_d[2:0]};
      vec_mode[vec_count]  = f_mode;
      vec_ready[vec_count] = f_rdy;
      vec_ramrd[vec_count] = f_rrd;
      vec_ctrl[vec_count]  = {f_cs, f_dis, f_hi, f_rdo, f_a15o};
      vec_we[vec_count]    = f_we;
      vec_oe[vec_count]    = f_oe;
      vec_count++;
    end
    $fclose(fd);
    if (vec_count == 0) begin
      other_errors++;
      $display("The vector file holds no vectors");
    end
  endtask

  task automatic report_and_finish();
    $display("Errors: ctrl %0d, strobe %0d, other %0d", ctrl_errors, bit_errors, other_errors);
    if (ctrl_errors + bit_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // Stops a stuck run after one clock per vector plus a margin for reset
  initial begin
    wait (loaded === 1'b1);
    #(vec_count * 4 + 200);
    other_errors++;
    $display("Timeout, the vectors did not finish in time");
    report_and_finish();
  end

  initial begin
    loaded       = 1'b0;
    vec_count    = 0;
    ctrl_errors  = 0;
    bit_errors   = 0;
    other_errors = 0;
    reset_b      = 1'b0;
    // Idle bus with every strobe high
    bus          = '{mreq_b: 1'b1, iorq_b: 1'b1, wr_b: 1'b1, rfsh_b: 1'b1, m1_b: 1'b1,
                     adr15: 1'b0, adr14: 1'b0, data_top: 5'd0, data_low: 3'd0};
    mode         = 2'b00;
    ready        = 1'b1;
    ramrd_b      = 1'b1;
    load_vectors();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_b = 1'b1;
    for (int k = 0; k < vec_count; k++) begin
      @(negedge clk);
      bus     = vec_bus[k];
      mode    = vec_mode[k];
      ready   = vec_ready[k];
      ramrd_b = vec_ramrd[k];
      // Registers take the vector at this edge and the outputs settle well before the next fall
      @(posedge clk);
      #1;
      check_ctrl("ctrl", vec_ctrl[k], ctrl);
      check_bit("ramwe_b", vec_we[k], ramwe_b);
      check_bit("ramoe_b", vec_oe[k], ramoe_b);
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- ram512k_props.sv
// Concurrent assertions on chip select, read overdrive and write FSM state order
`timescale 1ns/10ps
`default_nettype none

module ram512k_props (
  input logic                     clk,
  input logic                     reset_b,
  input cpc_bus_pkg::cpu_bus_t    bus,
  input cpc_bus_pkg::card_mode_t  mode,
  input ram_map_pkg::ram_ctrl_t   ctrl,
  input ram_map_pkg::wr_state_t   state
);

  // The SRAM must stay deselected outside a memory request
  a_cs_needs_mreq : assert property (@(posedge clk) disable iff (!reset_b)
    bus.mreq_b |-> ctrl.ramcs_b)
    else $error("ramcs_b low while mreq_b is high");

  // A 6128 host never gets rd_b pulled by the card
  a_rd_ovr_464_only : assert property (@(posedge clk) disable iff (!reset_b)
    !mode.overdrive_mode |-> !ctrl.rd_overdrive)
    else $error("rd_overdrive set outside 464 mode");

  // T2 lasts exactly one cycle
  a_t2_to_idle : assert property (@(posedge clk) disable iff (!reset_b)
    (state == ram_map_pkg::T2) |=> (state == ram_map_pkg::IDLE))
    else $error("write FSM did not return to IDLE after T2");

endmodule

// Attach to every instance of the top level and take the state from the FSM inside
bind ram512k_top ram512k_props ram512k_props_i (
  .clk     (clk),
  .reset_b (reset_b),
  .bus     (bus),
  .mode    (mode),
  .ctrl    (ctrl),
  .state   (mem_write_fsm_i.state)
);

`default_nettype wire

//--- ram512k_top.sv
// Top level of the 512K RAM card control with bank register, write FSM and mapper
`timescale 1ns/10ps
`default_nettype none

module ram512k_top (
  input  logic                      clk,
  input  logic                      reset_b,
  input  cpc_bus_pkg::cpu_bus_t     bus,
  input  cpc_bus_pkg::card_mode_t   mode,
  input  logic                      ready,
  input  logic                      ramrd_b,
  output ram_map_pkg::ram_ctrl_t    ctrl,
  output logic                      ramwe_b,
  output logic                      ramoe_b
);

  ram_map_pkg::bank_sel_t sel;
  logic                   mwr_cyc;

  bank_select_reg bank_select_reg_i (
    .clk     (clk),
    .reset_b (reset_b),
    .bus     (bus),
    .mode    (mode),
    .sel     (sel)
  );

  // The read overdrive feeds back so a pulled rd_b cannot start a new cycle
  mem_write_fsm mem_write_fsm_i (
    .clk          (clk),
    .reset_b      (reset_b),
    .bus          (bus),
    .ready        (ready),
    .rd_overdrive (ctrl.rd_overdrive),
    .mwr_cyc      (mwr_cyc)
  );

  ram_mapper ram_mapper_i (
    .clk     (clk),
    .reset_b (reset_b),
    .bus     (bus),
    .mode    (mode),
    .sel     (sel),
    .mwr_cyc (mwr_cyc),
    .ctrl    (ctrl)
  );

  // SRAM strobes come straight from the host, with the chip select gating them
  assign ramwe_b = bus.wr_b;
  assign ramoe_b = ramrd_b;

endmodule

`default_nettype wire

//--- ram_mapper.sv
// Block mapper from scheme and CPU address to SRAM chip select, high address and overdrives
`timescale 1ns/10ps
`default_nettype none
`include "ram512k_consts.svh"

module ram_mapper (
  input  logic                      clk,
  input  logic                      reset_b,
  input  cpc_bus_pkg::cpu_bus_t     bus,
  input  cpc_bus_pkg::card_mode_t   mode,
  input  ram_map_pkg::bank_sel_t    sel,
  input  logic                      mwr_cyc,
  output ram_map_pkg::ram_ctrl_t    ctrl
);

  logic       adr15_hold;
  logic [1:0] quad;
  logic [1:0] held_quad;
  logic       miss_cs_b;
  logic       exp_hit;
  logic       cs_sel_b;
  logic [4:0] adrhi;

  // adr15 follows the bus while mreq_b is high and is frozen for the memory cycle
  // In C3 the card forces adr15 high itself, so the decode must use the value seen before
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      adr15_hold <= `RAM_ADR15_HOLD_RESET;
    end else if (bus.mreq_b) begin
      adr15_hold <= bus.adr15;
    end
  end

  assign quad      = {bus.adr15, bus.adr14};
  assign held_quad = {adr15_hold, bus.adr14};

  // An access that misses the expansion goes to internal RAM in normal mode
  // In shadow mode it is also written into the shadow bank so reads can be served later
  assign miss_cs_b = mode.shadow_mode ? !mwr_cyc : `RAM_INTERNAL;

  // Scheme table
  // Each hit selects the SRAM and the block within the bank held in sel
  always_comb begin
    exp_hit  = 1'b0;
    cs_sel_b = miss_cs_b;
    adrhi    = {`RAM_SHADOW_BANK, quad};
    case (sel.scheme)
      // Top quarter only
      `RAM_SCHEME_C1: begin
        if (quad == 2'b11) begin
          exp_hit  = 1'b1;
          cs_sel_b = 1'b0;
          adrhi    = {sel.bank, 2'b11};
        end
      end
      // Whole 64K bank replaces the internal RAM
      `RAM_SCHEME_C2: begin
        exp_hit  = 1'b1;
        cs_sel_b = 1'b0;
        adrhi    = {sel.bank, quad};
      end
      // Top quarter from the expansion and internal block 3 seen at 0x4000
      `RAM_SCHEME_C3: begin
        if (held_quad == 2'b11) begin
          exp_hit  = 1'b1;
          cs_sel_b = 1'b0;
          adrhi    = {sel.bank, 2'b11};
        end else if (mode.shadow_mode && (held_quad == 2'b01)) begin
          // The internal block 3 copy lives in the shadow bank and is read from there
          cs_sel_b = 1'b0;
          adrhi    = {`RAM_SHADOW_BANK, 2'b11};
        end
      end
      // One block of the bank appears in the second quarter
      `RAM_SCHEME_C4, `RAM_SCHEME_C5, `RAM_SCHEME_C6, `RAM_SCHEME_C7: begin
        if (quad == 2'b01) begin
          exp_hit  = 1'b1;
          cs_sel_b = 1'b0;
          adrhi    = {sel.bank, sel.scheme[1:0]};
        end
      end
      // C0 keeps every quarter on the default mapping
      default: begin
        exp_hit  = 1'b0;
      end
    endcase
  end

  // The SRAM is only selected inside a real memory cycle and never during refresh
  assign ctrl.ramcs_b  = cs_sel_b | bus.mreq_b | !bus.rfsh_b;
  assign ctrl.ramdis   = !cs_sel_b;
  assign ctrl.ramadrhi = adrhi;

  // A 464 has no ramdis input, so the card holds rd_b low to keep the
  // internal RAM from writing the same byte
  assign ctrl.rd_overdrive = mode.overdrive_mode & exp_hit & mwr_cyc;

  // In C3 the 464 must see adr15 high at 0x4000 so internal block 3 is protected
  // With shadow RAM only writes need it since reads come from the shadow bank
  always_comb begin
    if (mode.shadow_mode) begin
      ctrl.adr15_overdrive = mode.overdrive_mode & sel.mode3 & bus.adr14 & mwr_cyc;
    end else begin
      ctrl.adr15_overdrive = mode.overdrive_mode & sel.mode3 & bus.adr14 & !bus.mreq_b;
    end
  end

endmodule

`default_nettype wire

//--- mem_write_fsm.sv
// Memory write FSM that flags the write window of a CPU memory cycle
`timescale 1ns/10ps
`default_nettype none
`include "ram512k_consts.svh"

module mem_write_fsm (
  input  logic                    clk,
  input  logic                    reset_b,
  input  cpc_bus_pkg::cpu_bus_t   bus,
  input  logic                    ready,
  input  logic                    rd_overdrive,
  output logic                    mwr_cyc
);

  ram_map_pkg::wr_state_t state;
  ram_map_pkg::wr_state_t state_next;
  logic                   mreq_b_q;
  logic                   ready_q;
  logic                   cyc_start;

  // Previous mreq_b and ready, so a falling mreq_b edge and a late ready can be seen
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      mreq_b_q <= `RAM_MREQ_B_RESET;
      ready_q  <= `RAM_READY_RESET;
    end else begin
      mreq_b_q <= bus.mreq_b;
      ready_q  <= ready;
    end
  end

  // A cycle starts on the first edge with mreq_b low after it was seen high
  // Refresh and opcode fetch cycles never start a write window
  // The card's own read overdrive also blocks a start while it is active
  assign cyc_start = !bus.mreq_b && mreq_b_q && bus.rfsh_b && bus.m1_b && !rd_overdrive;

  always_comb begin
    state_next = state;
    case (state)
      ram_map_pkg::IDLE: begin
        if (cyc_start) begin
          state_next = ram_map_pkg::T1;
        end
      end
      // Wait states stretch T1 until the registered ready comes back high
      ram_map_pkg::T1: begin
        if (ready_q) begin
          state_next = ram_map_pkg::T2;
        end
      end
      // The last half of the cycle always ends after one edge
      ram_map_pkg::T2: begin
        state_next = ram_map_pkg::IDLE;
      end
      default: begin
        state_next = ram_map_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      state <= ram_map_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // The write window covers both busy states
  assign mwr_cyc = (state == ram_map_pkg::T1) || (state == ram_map_pkg::T2);

endmodule

`default_nettype wire

//--- bank_select_reg.sv
// Bank select register with control byte decode, shadow bank alias and C3 predecode
`timescale 1ns/10ps
`default_nettype none
`include "ram512k_consts.svh"

module bank_select_reg (
  input  logic                      clk,
  input  logic                      reset_b,
  input  cpc_bus_pkg::cpu_bus_t     bus,
  input  cpc_bus_pkg::card_mode_t   mode,
  output ram_map_pkg::bank_sel_t    sel
);

  logic       io_wr;
  logic [2:0] bank_in;
  logic [2:0] bank_next;
  logic [2:0] scheme_in;

  // The register sits at any I/O address with adr15 low, as 0x7Fxx in the host map
  // Only bytes whose top two bits carry the tag are meant for this card
  assign io_wr = !bus.iorq_b && !bus.wr_b && !bus.adr15 &&
                 (bus.data_top[4:3] == `RAM_CTRL_TAG);

  assign bank_in   = bus.data_top[2:0];
  assign scheme_in = bus.data_low;

  // In shadow mode the shadow bank must not be reachable by the CPU as a normal bank
  // A request for it is moved to the bank with the middle bit cleared
  always_comb begin
    bank_next = bank_in;
    if (mode.shadow_mode && (bank_in == `RAM_SHADOW_BANK)) begin
      bank_next = {bank_in[2], 1'b0, bank_in[0]};
    end
  end

  // The new mapping is used from the cycle that follows the write edge
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      sel.bank   <= `RAM_BANK_RESET;
      sel.scheme <= `RAM_SCHEME_RESET;
      sel.mode3  <= 1'b0;
    end else if (io_wr) begin
      sel.bank   <= bank_next;
      sel.scheme <= scheme_in;
      // C3 needs the held adr15 and the overdrive of adr15 so flag it here
      sel.mode3  <= (scheme_in == `RAM_SCHEME_C3);
    end
  end

endmodule

`default_nettype wire

//--- ram_map_pkg.sv
// Types for the bank register, the memory write FSM states and the RAM side outputs
`default_nettype none

package ram_map_pkg;

  // Contents of the bank select register
  // The bank picks one of eight 64K banks of the expansion
  // The scheme picks how the four 16K quarters map onto that bank
  // mode3 is decoded at the register so the mapper gets it straight from a flop
  typedef struct packed {
    logic [2:0] bank;
    logic [2:0] scheme;
    logic       mode3;
  } bank_sel_t;

  // States of the memory write FSM
  // The codes of T1 and T2 differ in one bit so the write window decodes cleanly
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    T1   = 2'b01,
    T2   = 2'b11
  } wr_state_t;

  // Outputs toward the SRAM and the host bus
  // ramcs_b selects the expansion SRAM and ramdis disables the internal RAM
  // ramadrhi carries the bank and the 16K block, which form SRAM address bits 18 to 14
  // The two overdrive fields enable the drivers that pull rd_b low and force adr15 high
  typedef struct packed {
    logic       ramcs_b;
    logic       ramdis;
    logic [4:0] ramadrhi;
    logic       rd_overdrive;
    logic       adr15_overdrive;
  } ram_ctrl_t;

endpackage

`default_nettype wire

//--- cpc_bus_pkg.sv
// Types for the Z80 bus inputs seen by the card and for its configuration straps
`default_nettype none

package cpc_bus_pkg;

  // Z80 bus signals sampled by the card on the rising edge of clk
  // Only the two top address bits reach the card
  // The data byte is split into the tag and bank field and the scheme field
  typedef struct packed {
    logic       mreq_b;
    logic       iorq_b;
    logic       wr_b;
    logic       rfsh_b;
    logic       m1_b;
    logic       adr15;
    logic       adr14;
    // Data bits 7 to 3 hold the tag in 4:3 and the 64K bank in 2:0
    logic [4:0] data_top;
    // Data bits 2 to 0 hold the block scheme
    logic [2:0] data_low;
  } cpu_bus_t;

  // Static straps that choose how the card behaves in the host
  // overdrive_mode is set for a 464 host, clear for a 6128 host
  // shadow_mode enables the partial shadow copy of the internal RAM
  typedef struct packed {
    logic overdrive_mode;
    logic shadow_mode;
  } card_mode_t;

endpackage

`default_nettype wire

//--- ram512k_consts.svh
// Control byte tag, block scheme codes, shadow bank and reset values of the 512K RAM card
`ifndef RAM512K_CONSTS_SVH
`define RAM512K_CONSTS_SVH

// Top two bits of a control byte written to the bank register
`define RAM_CTRL_TAG        2'b11

// 64K bank that holds the shadow copy of the internal RAM in 464 mode
`define RAM_SHADOW_BANK     3'b011

// Block switching schemes held in the low three bits of the control byte
`define RAM_SCHEME_C0       3'b000
`define RAM_SCHEME_C1       3'b001
`define RAM_SCHEME_C2       3'b010
`define RAM_SCHEME_C3       3'b011
`define RAM_SCHEME_C4       3'b100
`define RAM_SCHEME_C5       3'b101
`define RAM_SCHEME_C6       3'b110
`define RAM_SCHEME_C7       3'b111

// Chip select level that leaves the access to the internal RAM
`define RAM_INTERNAL        1'b1

// Values loaded while reset_b is low
`define RAM_BANK_RESET      3'b000
`define RAM_SCHEME_RESET    `RAM_SCHEME_C0
`define RAM_MREQ_B_RESET    1'b1
`define RAM_READY_RESET     1'b1
`define RAM_ADR15_HOLD_RESET 1'b0

`endif
